// ==== rtl/cpu_pkg.sv ====
package cpu_pkg;

  localparam int DATA_BITS = 32;
  localparam int REG_BITS  = 4;
  localparam int IMM_BITS  = 16;

  typedef logic [DATA_BITS-1:0] data_t;
  typedef logic [DATA_BITS-1:0] addr_t;
  typedef logic [DATA_BITS-1:0] inst_t;
  typedef logic [REG_BITS-1:0]  reg_num_t;
  typedef logic [IMM_BITS-1:0]  imm_t;

  localparam addr_t INST_BYTES = 4;  // One instruction word

  // Primary opcode, inst[31:26]
  typedef enum logic [5:0] {
    ALUR = 6'b000000,
    BEQ  = 6'b001000,
    BLT  = 6'b001001,
    BLE  = 6'b001010,
    BNE  = 6'b001011,
    JAL  = 6'b001100,
    LW   = 6'b010010,
    SW   = 6'b011010,
    ADDI = 6'b100000,
    ANDI = 6'b100100,
    ORI  = 6'b100101,
    XORI = 6'b100110
  } op1_e;

  // Secondary opcode for ALUR, inst[25:18]
  typedef enum logic [7:0] {
    EQ   = 8'b00001000,
    LT   = 8'b00001001,
    LE   = 8'b00001010,
    NE   = 8'b00001011,
    ADD  = 8'b00100000,
    AND  = 8'b00100100,
    OR   = 8'b00100101,
    XOR  = 8'b00100110,
    SUB  = 8'b00101000,
    NAND = 8'b00101100,
    NOR  = 8'b00101101,
    NXOR = 8'b00101110,
    RSHF = 8'b00110000,
    LSHF = 8'b00110001
  } op2_e;

  typedef enum logic [1:0] {
    SRC_RT   = 2'b00,  // rt contents
    SRC_IMM  = 2'b01,  // sxt(imm)
    SRC_IMM4 = 2'b10   // sxt(imm) * 4
  } alu_src_e;

  typedef enum logic [1:0] {
    WR_PC4 = 2'b00,
    WR_MEM = 2'b01,
    WR_ALU = 2'b10
  } wr_src_e;

  typedef struct packed {
    alu_src_e alu_src;
    logic     mem_we;
    logic     mem_re;
    logic     reg_we;
    wr_src_e  wr_src;
    logic     dst_is_rd;
  } ctrl_t;

  typedef struct packed {
    logic  valid;
    addr_t pc;
    inst_t inst;
  } fd_t;

  typedef struct packed {
    logic     valid;
    addr_t    pc;
    op1_e     op1;
    op2_e     op2;
    data_t    rs_val;
    data_t    rt_val;
    data_t    imm;  // Already sign-extended
    reg_num_t dst;
    ctrl_t    ctrl;
  } de_t;

  typedef struct packed {
    logic     valid;
    addr_t    pc;
    data_t    alu_out;
    data_t    store_data;
    reg_num_t dst;
    logic     mem_we;
    logic     mem_re;
    logic     reg_we;
    wr_src_e  wr_src;
  } em_t;

  typedef struct packed {
    logic     valid;
    reg_num_t dst;
    data_t    data;
  } wb_t;

  typedef struct packed {
    logic  taken;
    addr_t target;
  } redirect_t;

endpackage

// ==== rtl/reg_file.sv ====
`timescale 1ns/1ns

module reg_file (
  input  logic              clk,
  input  logic              reset,
  input  cpu_pkg::reg_num_t rs_num,
  input  cpu_pkg::reg_num_t rt_num,
  input  cpu_pkg::wb_t      wb,
  output cpu_pkg::data_t    rs_val,
  output cpu_pkg::data_t    rt_val
);
  import cpu_pkg::*;

  localparam int NUM_REGS = 1 << REG_BITS;

  data_t regs [NUM_REGS];

  always_ff @(posedge clk or posedge reset) begin
    if (reset) begin
      for (int i = 0; i < NUM_REGS; i++) begin
        regs[i] <= '0;
      end
    end else if (wb.valid) begin
      regs[wb.dst] <= wb.data;
    end
  end

  // Same-cycle write is forwarded so decode never sees a stale value
  assign rs_val = (wb.valid && wb.dst == rs_num) ? wb.data : regs[rs_num];
  assign rt_val = (wb.valid && wb.dst == rt_num) ? wb.data : regs[rt_num];

endmodule

// ==== rtl/fetch_stage.sv ====
`timescale 1ns/1ns

module fetch_stage #(
  parameter cpu_pkg::addr_t START_PC = 'h100
) (
  input  logic               clk,
  input  logic               reset,
  input  logic               stall,
  input  cpu_pkg::redirect_t redirect,
  input  cpu_pkg::inst_t     imem_data,
  output cpu_pkg::addr_t     imem_addr,
  output cpu_pkg::fd_t       fd
);
  import cpu_pkg::*;

  addr_t pc;

  assign imem_addr = pc;  // ROM answers in the same cycle

  // Redirect wins over stall
  always_ff @(posedge clk or posedge reset) begin
    if (reset) begin
      pc <= START_PC;
    end else if (redirect.taken) begin
      pc <= redirect.target;
    end else if (!stall) begin
      pc <= pc + INST_BYTES;
    end
  end

  always_ff @(posedge clk or posedge reset) begin
    if (reset) begin
      fd <= '0;
    end else if (redirect.taken) begin
      fd.valid <= 1'b0;  // Squash the word fetched behind the branch
    end else if (!stall) begin
      fd <= '{valid: 1'b1, pc: pc, inst: imem_data};
    end
  end

endmodule

// ==== rtl/decode_stage.sv ====
`timescale 1ns/1ns

module decode_stage (
  input  logic               clk,
  input  logic               reset,
  input  cpu_pkg::fd_t       fd,
  input  cpu_pkg::redirect_t redirect,
  input  cpu_pkg::em_t       em,
  input  cpu_pkg::data_t     rs_val,
  input  cpu_pkg::data_t     rt_val,
  output cpu_pkg::reg_num_t  rs_num,
  output cpu_pkg::reg_num_t  rt_num,
  output logic               stall,
  output cpu_pkg::de_t       de
);
  import cpu_pkg::*;

  op1_e     op1;
  op2_e     op2;
  imm_t     imm;
  reg_num_t rd;
  ctrl_t    ctrl;
  logic     uses_rt;
  logic     hazard_ex;
  logic     hazard_mem;
  de_t      de_next;

  // True when an older writer targets one of our source registers
  function automatic logic conflict(input logic we, input reg_num_t dst,
                                    input reg_num_t rs, input reg_num_t rt,
                                    input logic chk_rt);
    return we && (dst == rs || (chk_rt && dst == rt));
  endfunction

  assign op1    = op1_e'(fd.inst[31:26]);
  assign op2    = op2_e'(fd.inst[25:18]);
  assign imm    = fd.inst[23:8];
  assign rd     = fd.inst[11:8];
  assign rs_num = fd.inst[7:4];
  assign rt_num = fd.inst[3:0];

  always_comb begin
    ctrl = '0;  // Unknown opcodes fall through as no-ops
    case (op1)
      ALUR: begin
        ctrl.reg_we    = 1'b1;
        ctrl.wr_src    = WR_ALU;
        ctrl.dst_is_rd = 1'b1;
      end
      BEQ, BLT, BLE, BNE: begin
        ctrl.alu_src = SRC_RT;  // Compare rs against rt
      end
      JAL: begin
        ctrl.alu_src = SRC_IMM4;
        ctrl.reg_we  = 1'b1;
        ctrl.wr_src  = WR_PC4;  // Link value
      end
      LW: begin
        ctrl.alu_src = SRC_IMM;
        ctrl.mem_re  = 1'b1;
        ctrl.reg_we  = 1'b1;
        ctrl.wr_src  = WR_MEM;
      end
      SW: begin
        ctrl.alu_src = SRC_IMM;
        ctrl.mem_we  = 1'b1;
      end
      ADDI, ANDI, ORI, XORI: begin
        ctrl.alu_src = SRC_IMM;
        ctrl.reg_we  = 1'b1;
        ctrl.wr_src  = WR_ALU;
      end
      default: begin
      end
    endcase
  end

  // rt is a source only for these
  assign uses_rt = op1 inside {ALUR, BEQ, BLT, BLE, BNE, SW};

  assign hazard_ex  = conflict(de.valid && de.ctrl.reg_we, de.dst, rs_num, rt_num, uses_rt);
  assign hazard_mem = conflict(em.valid && em.reg_we, em.dst, rs_num, rt_num, uses_rt);
  assign stall      = fd.valid && (hazard_ex || hazard_mem);

  always_comb begin
    de_next.valid  = fd.valid && !stall && !redirect.taken;  // Bubble otherwise
    de_next.pc     = fd.pc;
    de_next.op1    = op1;
    de_next.op2    = op2;
    de_next.rs_val = rs_val;
    de_next.rt_val = rt_val;
    de_next.imm    = {{(DATA_BITS-IMM_BITS){imm[IMM_BITS-1]}}, imm};
    de_next.dst    = ctrl.dst_is_rd ? rd : rt_num;
    de_next.ctrl   = ctrl;
  end

  always_ff @(posedge clk or posedge reset) begin
    if (reset) begin
      de <= '0;
    end else begin
      de <= de_next;
    end
  end

endmodule

// ==== rtl/execute_stage.sv ====
`timescale 1ns/1ns

module execute_stage (
  input  logic               clk,
  input  logic               reset,
  input  cpu_pkg::de_t       de,
  output cpu_pkg::redirect_t redirect,
  output cpu_pkg::em_t       em
);
  import cpu_pkg::*;

  data_t      op_a;
  data_t      op_b;
  data_t      imm4;
  data_t      alu_out;
  logic [4:0] shamt;
  logic       eq;
  logic       lt;
  logic       br_cond;
  logic       is_jal;

  assign imm4 = de.imm << 2;
  assign op_a = de.rs_val;

  always_comb begin
    case (de.ctrl.alu_src)
      SRC_IMM:  op_b = de.imm;
      SRC_IMM4: op_b = imm4;
      default:  op_b = de.rt_val;
    endcase
  end

  assign shamt = op_b[4:0];
  assign eq    = op_a == op_b;
  assign lt    = $signed(op_a) < $signed(op_b);  // All compares are signed

  always_comb begin
    alu_out = '0;
    case (de.op1)
      ALUR: begin
        case (de.op2)
          EQ:      alu_out = data_t'(eq);
          LT:      alu_out = data_t'(lt);
          LE:      alu_out = data_t'(lt || eq);
          NE:      alu_out = data_t'(!eq);
          ADD:     alu_out = op_a + op_b;
          AND:     alu_out = op_a & op_b;
          OR:      alu_out = op_a | op_b;
          XOR:     alu_out = op_a ^ op_b;
          SUB:     alu_out = op_a - op_b;
          NAND:    alu_out = ~(op_a & op_b);
          NOR:     alu_out = ~(op_a | op_b);
          NXOR:    alu_out = op_a ~^ op_b;
          RSHF:    alu_out = $signed(op_a) >>> shamt;
          LSHF:    alu_out = op_a << shamt;
          default: alu_out = '0;
        endcase
      end
      LW, SW, ADDI, JAL: alu_out = op_a + op_b;  // Address or JAL target
      ANDI:    alu_out = op_a & op_b;
      ORI:     alu_out = op_a | op_b;
      XORI:    alu_out = op_a ^ op_b;
      default: alu_out = '0;
    endcase
  end

  always_comb begin
    case (de.op1)
      BEQ:     br_cond = eq;
      BLT:     br_cond = lt;
      BLE:     br_cond = lt || eq;
      BNE:     br_cond = !eq;
      default: br_cond = 1'b0;
    endcase
  end

  assign is_jal = de.op1 == JAL;

  assign redirect.taken  = de.valid && (br_cond || is_jal);
  assign redirect.target = is_jal ? alu_out : de.pc + INST_BYTES + imm4;

  always_ff @(posedge clk or posedge reset) begin
    if (reset) begin
      em <= '0;
    end else begin
      em.valid      <= de.valid;
      em.pc         <= de.pc;
      em.alu_out    <= alu_out;
      em.store_data <= de.rt_val;
      em.dst        <= de.dst;
      em.mem_we     <= de.ctrl.mem_we;
      em.mem_re     <= de.ctrl.mem_re;
      em.reg_we     <= de.ctrl.reg_we;
      em.wr_src     <= de.ctrl.wr_src;
    end
  end

endmodule

// ==== rtl/memory_stage.sv ====
`timescale 1ns/1ns

module memory_stage #(
  parameter int DMEM_WORDS = 1024  // Power of two
) (
  input  logic         clk,
  input  logic         reset,
  input  cpu_pkg::em_t em,
  output cpu_pkg::wb_t wb
);
  import cpu_pkg::*;

  localparam int IDX_BITS = $clog2(DMEM_WORDS);

  data_t               dmem [DMEM_WORDS];
  logic [IDX_BITS-1:0] word_idx;
  data_t               load_data;
  data_t               wr_data;

  // Byte address to word index
  assign word_idx = em.alu_out[IDX_BITS+1:2];

  always_ff @(posedge clk) begin
    if (em.valid && em.mem_we) begin
      dmem[word_idx] <= em.store_data;
    end
  end

  assign load_data = em.mem_re ? dmem[word_idx] : '0;

  always_comb begin
    case (em.wr_src)
      WR_PC4:  wr_data = em.pc + INST_BYTES;  // JAL link
      WR_MEM:  wr_data = load_data;
      default: wr_data = em.alu_out;
    endcase
  end

  always_ff @(posedge clk or posedge reset) begin
    if (reset) begin
      wb <= '0;
    end else begin
      wb <= '{valid: em.valid && em.reg_we, dst: em.dst, data: wr_data};
    end
  end

endmodule

// ==== rtl/cpu_top.sv ====
`timescale 1ns/1ns

module cpu_top #(
  parameter cpu_pkg::addr_t START_PC   = 'h100,
  parameter int             DMEM_WORDS = 1024
) (
  input  logic           clk,
  input  logic           reset,
  input  cpu_pkg::inst_t imem_data,
  output cpu_pkg::addr_t imem_addr,
  output cpu_pkg::wb_t   wb
);
  import cpu_pkg::*;

  fd_t       fd;
  de_t       de;
  em_t       em;
  redirect_t redirect;
  logic      stall;
  reg_num_t  rs_num;
  reg_num_t  rt_num;
  data_t     rs_val;
  data_t     rt_val;

  fetch_stage #(.START_PC(START_PC)) u_fetch (
    .clk      (clk),
    .reset    (reset),
    .stall    (stall),
    .redirect (redirect),
    .imem_data(imem_data),
    .imem_addr(imem_addr),
    .fd       (fd)
  );

  decode_stage u_decode (
    .clk     (clk),
    .reset   (reset),
    .fd      (fd),
    .redirect(redirect),
    .em      (em),
    .rs_val  (rs_val),
    .rt_val  (rt_val),
    .rs_num  (rs_num),
    .rt_num  (rt_num),
    .stall   (stall),
    .de      (de)
  );

  execute_stage u_execute (
    .clk     (clk),
    .reset   (reset),
    .de      (de),
    .redirect(redirect),
    .em      (em)
  );

  memory_stage #(.DMEM_WORDS(DMEM_WORDS)) u_memory (
    .clk  (clk),
    .reset(reset),
    .em   (em),
    .wb   (wb)
  );

  reg_file u_regs (
    .clk   (clk),
    .reset (reset),
    .rs_num(rs_num),
    .rt_num(rt_num),
    .wb    (wb),
    .rs_val(rs_val),
    .rt_val(rt_val)
  );

endmodule

// ==== verif/cpu_assertions.sv ====
`timescale 1ns/1ns

module cpu_assertions #(
  parameter cpu_pkg::addr_t START_PC = 'h100
) (
  input logic           clk,
  input logic           reset,
  input cpu_pkg::addr_t imem_addr,
  input cpu_pkg::wb_t   wb
);

  // Nothing retires in the first cycle out of reset
  wb_quiet_after_reset: assert property (@(posedge clk) $fell(reset) |-> !wb.valid)
    else $error("wb.valid high in the cycle after reset");

  fetch_word_aligned: assert property (@(posedge clk) disable iff (reset)
    imem_addr[1:0] == 2'b00)
    else $error("imem_addr %h not word aligned", imem_addr);

  fetch_starts_at_reset_pc: assert property (@(posedge clk) $fell(reset) |->
    imem_addr == START_PC)
    else $error("imem_addr %h after reset", imem_addr);

endmodule

bind cpu_top cpu_assertions #(.START_PC(START_PC)) u_assertions (
  .clk      (clk),
  .reset    (reset),
  .imem_addr(imem_addr),
  .wb       (wb)
);

// ==== verif/cpu_tb.sv ====
`timescale 1ns/1ns

module cpu_tb;
  import cpu_pkg::*;

  localparam addr_t START_PC    = 'h100;
  localparam int    PROG_WORDS  = 64;
  localparam int    NUM_TESTS   = 5;
  localparam int    CYCLE_LIMIT = 200 * NUM_TESTS;

  logic  clk;
  logic  reset;
  inst_t imem_data;
  addr_t imem_addr;
  wb_t   wb;

  inst_t    prog [PROG_WORDS];
  int       prog_len;
  addr_t    rom_off;
  data_t    model_regs [16];
  reg_num_t exp_dst [$];
  data_t    exp_data [$];
  reg_num_t got_dst [$];
  data_t    got_data [$];
  logic     collecting;
  int       cycles = 0;
  int       test_errors;
  int       total_errors;
  int       tests_run;
  int       tests_failed;

  cpu_top #(.START_PC(START_PC), .DMEM_WORDS(1024)) uut (
    .clk      (clk),
    .reset    (reset),
    .imem_data(imem_data),
    .imem_addr(imem_addr),
    .wb       (wb)
  );

  initial begin
    clk = 1'b0;
    forever #4 clk = ~clk;
  end

  // Program ROM with unused words holding an unknown opcode tagged by address
  always_comb begin
    rom_off = (imem_addr - START_PC) >> 2;
    if (rom_off < addr_t'(prog_len)) imem_data = prog[rom_off[5:0]];
    else imem_data = {6'h3f, imem_addr[25:0] ^ {20'd0, imem_addr[31:26]}};
  end

  always @(negedge clk) begin
    if (collecting && wb.valid) begin
      got_dst.push_back(wb.dst);
      got_data.push_back(wb.data);
    end
  end

  always @(posedge clk) begin
    cycles <= cycles + 1;
    if (cycles >= CYCLE_LIMIT) begin
      $display("Timeout: run went past %0d cycles without finishing", CYCLE_LIMIT);
      $display("*** TEST FAILED ***");
      $finish;
    end
  end

  function automatic inst_t enc_r(op2_e op2, reg_num_t rd, reg_num_t rs, reg_num_t rt);
    return {ALUR, op2, 6'b000000, rd, rs, rt};
  endfunction

  function automatic inst_t enc_i(op1_e op, imm_t imm, reg_num_t rs, reg_num_t rt);
    return {op, 2'b00, imm, rs, rt};
  endfunction

  function automatic data_t sxt(imm_t imm);
    return {{16{imm[15]}}, imm};
  endfunction

  // Reference result of a register ALU op from the ISA rules
  function automatic data_t alu_expect(op2_e op, data_t a, data_t b);
    data_t r;
    r = a;
    case (op)
      EQ:   r = (a == b) ? 32'd1 : 32'd0;
      LT:   r = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
      LE:   r = ($signed(b) < $signed(a)) ? 32'd0 : 32'd1;
      NE:   r = (a != b) ? 32'd1 : 32'd0;
      ADD:  r = a + b;
      AND:  r = a & b;
      OR:   r = a | b;
      XOR:  r = a ^ b;
      SUB:  r = a + ~b + 32'd1;
      NAND: r = ~(a & b);
      NOR:  r = ~(a | b);
      NXOR: r = ~(a ^ b);
      RSHF: for (int k = 0; k < int'(b[4:0]); k++) r = {r[31], r[31:1]};
      LSHF: for (int k = 0; k < int'(b[4:0]); k++) r = {r[30:0], 1'b0};
      default: r = '0;
    endcase
    return r;
  endfunction

  task automatic start_program();
    prog_len = 0;
    exp_dst.delete();
    exp_data.delete();
    got_dst.delete();
    got_data.delete();
    for (int i = 0; i < 16; i++) model_regs[i] = '0;
  endtask

  task automatic emit(inst_t inst);
    prog[prog_len] = inst;
    prog_len++;
  endtask

  task automatic expect_write(reg_num_t dst, data_t val);
    exp_dst.push_back(dst);
    exp_data.push_back(val);
    model_regs[dst] = val;
  endtask

  task automatic compare_data(string name, int idx, data_t exp, data_t act);
    if (exp !== act) begin
      $display("error %s: writeback %0d data expected %h actual %h", name, idx, exp, act);
      test_errors++;
    end
  endtask

  task automatic compare_reg(string name, int idx, reg_num_t exp, reg_num_t act);
    if (exp !== act) begin
      $display("error %s: writeback %0d register expected %0d actual %0d", name, idx, exp, act);
      test_errors++;
    end
  endtask

  task automatic compare_count(string name, int exp, int act);
    if (exp != act) begin
      $display("error %s: writeback count expected %0d actual %0d", name, exp, act);
      test_errors++;
    end
  endtask

  // Appends the closing self-branch BEQ r0,r0,-1 and runs the program
  task automatic run_and_check(string name);
    addr_t halt_pc;
    int    entries;
    logic  at_halt;
    int    n;
    emit(enc_i(BEQ, 16'hffff, 4'd0, 4'd0));
    halt_pc     = START_PC + addr_t'((prog_len - 1) * 4);
    test_errors = 0;
    entries     = 0;
    at_halt     = 1'b0;
    @(posedge clk);
    reset      <= 1'b1;
    collecting <= 1'b0;
    repeat (3) @(posedge clk);
    reset      <= 1'b0;
    collecting <= 1'b1;
    // Second arrival at the halt word means the self-branch resolved once
    while (entries < 2) begin
      @(negedge clk);
      if (imem_addr == halt_pc && !at_halt) entries++;
      at_halt = (imem_addr == halt_pc);
    end
    repeat (4) @(negedge clk);  // Older instructions drain
    @(posedge clk);
    collecting <= 1'b0;
    compare_count(name, exp_dst.size(), got_dst.size());
    n = (exp_dst.size() < got_dst.size()) ? exp_dst.size() : got_dst.size();
    for (int i = 0; i < n; i++) begin
      compare_reg(name, i, exp_dst[i], got_dst[i]);
      compare_data(name, i, exp_data[i], got_data[i]);
    end
    tests_run++;
    total_errors += test_errors;
    if (test_errors == 0) begin
      $display("%s: ok, %0d writebacks", name, got_dst.size());
    end else begin
      tests_failed++;
      $display("%s: %0d errors", name, test_errors);
    end
  endtask

  task automatic test_immediate();
    imm_t a;
    imm_t b;
    imm_t c;
    imm_t d;
    a = imm_t'($urandom);
    b = imm_t'($urandom);
    c = imm_t'($urandom);
    d = imm_t'($urandom);
    start_program();
    emit(enc_i(ADDI, a, 4'd0, 4'd1));
    expect_write(4'd1, sxt(a));
    emit(enc_i(ORI, b, 4'd0, 4'd2));
    expect_write(4'd2, sxt(b));
    emit(enc_i(XORI, c, 4'd0, 4'd3));
    expect_write(4'd3, sxt(c));
    emit(enc_i(ANDI, d, 4'd0, 4'd4));
    expect_write(4'd4, 32'd0);
    emit(enc_i(ANDI, d, 4'd1, 4'd5));
    expect_write(4'd5, model_regs[1] & sxt(d));
    emit(enc_i(XORI, a, 4'd2, 4'd6));
    expect_write(4'd6, model_regs[2] ^ sxt(a));
    emit(enc_i(ADDI, b, 4'd3, 4'd7));
    expect_write(4'd7, model_regs[3] + sxt(b));
    emit(enc_i(ORI, c, 4'd1, 4'd8));
    expect_write(4'd8, model_regs[1] | sxt(c));
    run_and_check("immediate");
  endtask

  task automatic test_alu_reg();
    op2_e     ops [14];
    imm_t     a;
    imm_t     b;
    reg_num_t rd;
    ops = '{EQ, LT, LE, NE, ADD, AND, OR, XOR, SUB, NAND, NOR, NXOR, RSHF, LSHF};
    a = imm_t'($urandom);
    b = imm_t'($urandom);
    start_program();
    emit(enc_i(ADDI, a, 4'd0, 4'd1));
    expect_write(4'd1, sxt(a));
    emit(enc_i(ADDI, b, 4'd0, 4'd2));
    expect_write(4'd2, sxt(b));
    for (int i = 0; i < 14; i++) begin
      rd = reg_num_t'(3 + i % 13);
      emit(enc_r(ops[i], rd, 4'd1, 4'd2));
      expect_write(rd, alu_expect(ops[i], model_regs[1], model_regs[2]));
    end
    emit(enc_r(ADD, 4'd4, 4'd3, 4'd15));  // Reads r3 written just before
    expect_write(4'd4, alu_expect(ADD, model_regs[3], model_regs[15]));
    emit(enc_r(LE, 4'd5, 4'd4, 4'd4));
    expect_write(4'd5, 32'd1);
    emit(enc_r(SUB, 4'd6, 4'd5, 4'd1));
    expect_write(4'd6, alu_expect(SUB, model_regs[5], model_regs[1]));
    run_and_check("alu_reg");
  endtask

  task automatic test_load_store();
    imm_t a;
    imm_t b;
    a = imm_t'($urandom);
    b = imm_t'($urandom);
    start_program();
    emit(enc_i(ADDI, a, 4'd0, 4'd1));
    expect_write(4'd1, sxt(a));
    emit(enc_i(ADDI, b, 4'd0, 4'd2));
    expect_write(4'd2, sxt(b));
    emit(enc_i(ADDI, 16'h0040, 4'd0, 4'd5));
    expect_write(4'd5, 32'h40);
    emit(enc_i(SW, 16'h0000, 4'd5, 4'd1));
    emit(enc_i(SW, 16'h0004, 4'd5, 4'd2));
    emit(enc_i(LW, 16'h0000, 4'd5, 4'd3));
    expect_write(4'd3, sxt(a));
    emit(enc_i(LW, 16'h0004, 4'd5, 4'd4));
    expect_write(4'd4, sxt(b));
    emit(enc_i(SW, 16'hfffc, 4'd5, 4'd4));
    emit(enc_i(LW, 16'hfffc, 4'd5, 4'd6));
    expect_write(4'd6, sxt(b));
    emit(enc_i(LW, 16'h0000, 4'd5, 4'd7));
    expect_write(4'd7, sxt(a));
    run_and_check("load_store");
  endtask

  // Branch over two ADDIs to r9, then a marker write to r10
  task automatic emit_branch_case(op1_e op, reg_num_t rs, reg_num_t rt, logic taken, int tag);
    emit(enc_i(op, 16'h0002, rs, rt));
    emit(enc_i(ADDI, imm_t'(tag), 4'd0, 4'd9));
    if (!taken) expect_write(4'd9, data_t'(tag));
    emit(enc_i(ADDI, imm_t'(tag + 1), 4'd0, 4'd9));
    if (!taken) expect_write(4'd9, data_t'(tag + 1));
    emit(enc_i(ADDI, imm_t'(tag + 2), 4'd0, 4'd10));
    expect_write(4'd10, data_t'(tag + 2));
  endtask

  task automatic test_branches();
    start_program();
    emit(enc_i(ADDI, 16'h0005, 4'd0, 4'd1));
    expect_write(4'd1, 32'd5);
    emit(enc_i(ADDI, 16'hfffd, 4'd0, 4'd2));  // -3
    expect_write(4'd2, 32'hffff_fffd);
    emit_branch_case(BEQ, 4'd1, 4'd1, 1'b1, 16);
    emit_branch_case(BEQ, 4'd1, 4'd2, 1'b0, 32);
    emit_branch_case(BLT, 4'd2, 4'd1, 1'b1, 48);
    emit_branch_case(BLT, 4'd1, 4'd2, 1'b0, 64);
    emit_branch_case(BLE, 4'd1, 4'd1, 1'b1, 80);
    emit_branch_case(BLE, 4'd1, 4'd2, 1'b0, 96);
    emit_branch_case(BNE, 4'd1, 4'd2, 1'b1, 112);
    emit_branch_case(BNE, 4'd2, 4'd2, 1'b0, 128);
    run_and_check("branches");
  endtask

  task automatic test_jal();
    start_program();
    emit(enc_i(ADDI, 16'h0100, 4'd0, 4'd1));
    expect_write(4'd1, 32'h100);
    emit(enc_i(JAL, 16'h0005, 4'd1, 4'd7));  // Sits at 0x104 and lands on 0x114
    expect_write(4'd7, 32'h108);
    emit(enc_i(ADDI, 16'h0bad, 4'd0, 4'd9));
    emit(enc_i(ADDI, 16'h0bad, 4'd0, 4'd9));
    emit(enc_i(ADDI, 16'h0bad, 4'd0, 4'd9));
    emit(enc_i(ADDI, 16'h0055, 4'd0, 4'd10));
    expect_write(4'd10, 32'h55);
    emit(enc_r(ADD, 4'd11, 4'd7, 4'd10));
    expect_write(4'd11, 32'h15d);
    run_and_check("jal");
  endtask

  initial begin
    void'($urandom(13099));
    reset        = 1'b1;
    collecting   = 1'b0;
    prog_len     = 0;
    total_errors = 0;
    tests_run    = 0;
    tests_failed = 0;
    test_immediate();
    test_alu_reg();
    test_load_store();
    test_branches();
    test_jal();
    $display("Tests run %0d, failed %0d, errors %0d", tests_run, tests_failed, total_errors);
    if (total_errors == 0) begin
      $display("*** TEST PASSED ***");
    end else begin
      $display("*** TEST FAILED ***");
    end
    $finish;
  end

endmodule

// ==== build.f ====
rtl/cpu_pkg.sv
rtl/reg_file.sv
rtl/fetch_stage.sv
rtl/decode_stage.sv
rtl/execute_stage.sv
rtl/memory_stage.sv
rtl/cpu_top.sv
verif/cpu_assertions.sv
verif/cpu_tb.sv

// ==== run.sh ====
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert --top-module cpu_tb -f build.f -o cpu_sim

out=$(./obj_dir/cpu_sim)
echo "$out"

echo "$out" | grep -q -F "*** TEST PASSED ***"
